//--- rtl/phold_pkg.sv
`default_nettype none

package phold_pkg;

   typedef logic [15:0] sim_time_t;    // Event timestamp
   typedef logic [2:0]  lp_id_t;       // Logical process number
   typedef logic [7:0]  rnd_t;
   typedef logic [7:0]  time_ofs_t;    // Gap from an event to its successor
   typedef logic [4:0]  hist_cnt_t;    // 0 to 16 entries

   localparam int NUM_LP = 2 ** $bits(lp_id_t);

   // Event message as it travels between cores
   typedef struct packed {
      logic [11:0] pad;
      logic        is_cancel;          // Anti-message
      lp_id_t      lp;
      sim_time_t   ts;
   } evt_msg_t;

   // One processed event, kept until GVT passes it
   typedef struct packed {
      logic        pad;
      lp_id_t      target;             // LP of the generated successor
      time_ofs_t   ofs;
      logic        is_cancel;
      lp_id_t      lp;
      sim_time_t   ts;
   } hist_entry_t;

   // Minimum time between an event and the event it generates
   localparam sim_time_t MIN_GAP = 16'd10;

   // Cancel to LP 0 at time 0, sent when an event produces nothing
   localparam evt_msg_t NULL_MSG = '{pad: '0, is_cancel: 1'b1, lp: '0, ts: '0};

   typedef enum logic [2:0] {
      IDLE,
      READ_HIST,
      FILTER_END,
      GEN_EVT,
      WRITE_HIST,
      SEND
   } ctrl_state_t;

endpackage

`default_nettype wire

//--- rtl/fwft_fifo.sv
`default_nettype none

module fwft_fifo #(
   parameter int DEPTH = 16,
   parameter int WIDTH = 32
) (
   input  wire logic             clk,
   input  wire logic             rst_n,
   input  wire logic             clear,
   input  wire logic             wr_en,
   input  wire logic [WIDTH-1:0] din,
   input  wire logic             rd_en,
   output logic [WIDTH-1:0]      dout,
   output logic                  empty,
   output logic                  full
);
   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   logic [WIDTH-1:0] mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             push;
   logic             pop;

   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
      return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   assign push  = wr_en && !full;     // Writes to a full buffer are dropped
   assign pop   = rd_en && !empty;
   assign dout  = mem[rd_ptr];        // Head word shows without a read
   assign empty = (count == '0);
   assign full  = (count == CNT_W'(DEPTH));

   always_ff @(posedge clk) begin
      if (!rst_n || clear) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (pop) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         count <= count + CNT_W'(push) - CNT_W'(pop);
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= din;
      end
   end

endmodule

`default_nettype wire

//--- rtl/hist_store.sv
`default_nettype none

module hist_store #(
   parameter int HIST_DEPTH = 16
) (
   input  wire logic                          clk,
   input  wire logic                          rst_n,
   input  wire phold_pkg::lp_id_t             lp,
   input  wire logic                          rd_en,
   input  wire logic [$clog2(HIST_DEPTH)-1:0] rd_idx,
   input  wire logic                          wr_en,
   input  wire logic [$clog2(HIST_DEPTH)-1:0] wr_idx,
   input  wire phold_pkg::hist_entry_t        wr_entry,
   input  wire logic                          set_cnt,
   input  wire phold_pkg::hist_cnt_t          new_cnt,
   output phold_pkg::hist_entry_t             rd_entry,
   output phold_pkg::hist_cnt_t               cnt
);
   import phold_pkg::*;

   localparam int IDX_W = $clog2(HIST_DEPTH);

   hist_entry_t                      mem [NUM_LP * HIST_DEPTH];
   hist_cnt_t                        cnt_q [NUM_LP];
   logic [$bits(lp_id_t)+IDX_W-1:0]  rd_addr;
   logic [$bits(lp_id_t)+IDX_W-1:0]  wr_addr;

   // Each LP owns a block of HIST_DEPTH consecutive words
   assign rd_addr = {lp, rd_idx};
   assign wr_addr = {lp, wr_idx};
   assign cnt     = cnt_q[lp];

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_entry;
      end
      if (rd_en) begin
         rd_entry <= mem[rd_addr];    // Data one cycle after the request
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < NUM_LP; i++) begin
            cnt_q[i] <= '0;
         end
      end else if (set_cnt) begin
         cnt_q[lp] <= new_cnt;
      end
   end

endmodule

`default_nettype wire

//--- rtl/event_decode.sv
`default_nettype none

module event_decode (
   input  wire logic                 clk,
   input  wire logic                 accept,
   input  wire phold_pkg::evt_msg_t  event_msg,
   input  wire phold_pkg::sim_time_t gvt,
   input  wire phold_pkg::rnd_t      random_in,
   output phold_pkg::evt_msg_t       cur_evt,
   output phold_pkg::sim_time_t      cur_gvt,
   output phold_pkg::evt_msg_t       new_msg,
   output phold_pkg::hist_entry_t    new_entry
);
   import phold_pkg::*;

   rnd_t      rnd;
   sim_time_t gen_ts;
   lp_id_t    gen_lp;

   always_ff @(posedge clk) begin
      if (accept) begin
         cur_evt <= event_msg;
         cur_gvt <= gvt;
         rnd     <= random_in;
      end
   end

   // Low random bits spread the successor in time, high bits pick its LP
   assign gen_ts = cur_evt.ts + MIN_GAP + sim_time_t'(rnd[4:0]);
   assign gen_lp = rnd[7:5];

   always_comb begin
      new_msg           = '0;
      new_msg.is_cancel = 1'b0;
      new_msg.lp        = gen_lp;
      new_msg.ts        = gen_ts;

      new_entry           = '0;
      new_entry.target    = gen_lp;
      new_entry.ofs       = time_ofs_t'(gen_ts - cur_evt.ts);
      new_entry.is_cancel = cur_evt.is_cancel;
      new_entry.lp        = cur_evt.lp;
      new_entry.ts        = cur_evt.ts;
   end

endmodule

`default_nettype wire

//--- rtl/hist_filter.sv
`default_nettype none

module hist_filter (
   input  wire logic                   clk,
   input  wire logic                   rst_n,
   input  wire logic                   clear,
   input  wire logic                   filt_vld,
   input  wire phold_pkg::hist_entry_t entry,
   input  wire phold_pkg::evt_msg_t    cur_evt,
   input  wire phold_pkg::sim_time_t   cur_gvt,
   output logic                        keep,
   output logic                        rollback,
   output logic                        discard_cur,
   output logic                        gen_cancel,
   output phold_pkg::evt_msg_t         cancel_msg
);
   import phold_pkg::*;

   logic      expired;
   logic      annihilate;
   logic      late;
   sim_time_t succ_ts;

   // Older than GVT, can never be rolled back
   assign expired = (entry.ts < cur_gvt);

   // Event and anti-message cancel each other, only the first match counts
   assign annihilate = !expired && !discard_cur &&
                       (entry.is_cancel != cur_evt.is_cancel) &&
                       (entry.ts == cur_evt.ts);

   // Straggler, this entry was processed too early
   assign late = !expired && !annihilate &&
                 !entry.is_cancel && !cur_evt.is_cancel &&
                 (entry.ts > cur_evt.ts);

   assign rollback = filt_vld && late;
   assign keep     = filt_vld && !expired && !annihilate && !late;

   assign succ_ts = entry.ts + sim_time_t'(entry.ofs);

   always_ff @(posedge clk) begin
      if (!rst_n || clear) begin
         discard_cur <= 1'b0;
         gen_cancel  <= 1'b0;
      end else if (filt_vld && annihilate) begin
         discard_cur <= 1'b1;
         gen_cancel  <= cur_evt.is_cancel;   // Successor already went out
      end
   end

   // Anti-message chasing the successor of the annihilated entry
   always_ff @(posedge clk) begin
      if (filt_vld && annihilate && cur_evt.is_cancel) begin
         cancel_msg <= '{pad: '0, is_cancel: 1'b1, lp: entry.target, ts: succ_ts};
      end
   end

endmodule

`default_nettype wire

//--- rtl/event_ctrl.sv
`default_nettype none

module event_ctrl #(
   parameter int HIST_DEPTH = 16
) (
   input  wire logic                   clk,
   input  wire logic                   rst_n,
   input  wire logic                   event_valid,
   input  wire phold_pkg::evt_msg_t    cur_evt,
   input  wire phold_pkg::hist_entry_t new_entry,
   input  wire phold_pkg::hist_cnt_t   hist_cnt,
   input  wire phold_pkg::hist_entry_t rd_entry,
   input  wire logic                   keep,
   input  wire logic                   discard_cur,
   input  wire logic                   send_done,
   output logic                        ready,
   output logic                        accept,
   output logic                        rd_en,
   output logic [$clog2(HIST_DEPTH)-1:0] rd_idx,
   output logic                        filt_vld,
   output logic                        clear,
   output logic                        wr_en,
   output logic [$clog2(HIST_DEPTH)-1:0] wr_idx,
   output phold_pkg::hist_entry_t      wr_entry,
   output logic                        set_cnt,
   output phold_pkg::hist_cnt_t        new_cnt,
   output logic                        send_start
);
   import phold_pkg::*;

   localparam int IDX_W = $clog2(HIST_DEPTH);

   ctrl_state_t state;
   ctrl_state_t state_nxt;
   hist_cnt_t   pos;            // Read or write position in the LP's history
   logic        gen_wr;
   logic        buf_wr;
   logic        buf_empty;
   logic        buf_full;
   hist_entry_t buf_din;

   assign ready  = (state == IDLE);
   assign accept = ready && event_valid;
   assign clear  = (state == IDLE);

   assign rd_en  = (state == READ_HIST) && (pos < hist_cnt);
   assign rd_idx = pos[IDX_W-1:0];

   assign gen_wr  = (state == GEN_EVT) && !discard_cur && !buf_full;
   assign buf_wr  = (filt_vld && keep) || gen_wr;
   assign buf_din = gen_wr ? new_entry : rd_entry;

   assign wr_en   = (state == WRITE_HIST) && !buf_empty;   // Drain buffer from index 0
   assign wr_idx  = pos[IDX_W-1:0];
   assign set_cnt = (state == WRITE_HIST) && buf_empty;
   assign new_cnt = pos;

   always_comb begin
      state_nxt = state;
      case (state)
         IDLE:       if (accept) state_nxt = READ_HIST;
         READ_HIST:  if (pos == hist_cnt) state_nxt = FILTER_END;   // Last entry in filter
         FILTER_END: state_nxt = GEN_EVT;
         GEN_EVT:    state_nxt = WRITE_HIST;
         WRITE_HIST: if (buf_empty) state_nxt = SEND;
         SEND:       if (send_done) state_nxt = IDLE;
         default:    state_nxt = IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state      <= IDLE;
         pos        <= '0;
         filt_vld   <= 1'b0;
         send_start <= 1'b0;
      end else begin
         state      <= state_nxt;
         filt_vld   <= rd_en;      // Entry returns a cycle after its read
         send_start <= set_cnt;    // High in the first SEND cycle
         if (state == IDLE || state == GEN_EVT) begin
            pos <= '0;
         end else if (rd_en || wr_en) begin
            pos <= pos + 1'b1;
         end
      end
   end

   // Surviving entries plus the new one, in index order
   fwft_fifo #(
      .DEPTH (HIST_DEPTH),
      .WIDTH ($bits(hist_entry_t))
   ) i_hist_buf (
      .clk   (clk),
      .rst_n (rst_n),
      .clear (clear),
      .wr_en (buf_wr),
      .din   (buf_din),
      .rd_en (wr_en),
      .dout  (wr_entry),
      .empty (buf_empty),
      .full  (buf_full)
   );

endmodule

`default_nettype wire

//--- rtl/event_result.sv
`default_nettype none

module event_result #(
   parameter int HIST_DEPTH = 16
) (
   input  wire logic                   clk,
   input  wire logic                   rst_n,
   input  wire logic                   rollback,
   input  wire phold_pkg::hist_entry_t rb_entry,
   input  wire phold_pkg::evt_msg_t    cur_evt,
   input  wire phold_pkg::evt_msg_t    new_msg,
   input  wire logic                   discard_cur,
   input  wire logic                   gen_cancel,
   input  wire phold_pkg::evt_msg_t    cancel_msg,
   input  wire logic                   send_start,
   input  wire logic                   ack,
   output logic                        out_valid,
   output phold_pkg::evt_msg_t         out_msg,
   output logic                        send_done
);
   import phold_pkg::*;

   hist_entry_t rb_head;
   logic        rb_empty;
   logic        rb_pop;
   logic        rb_second;    // Head's cancel is showing, its regular message is next
   logic        step;
   evt_msg_t    primary;
   evt_msg_t    rb_cncl;
   evt_msg_t    rb_evt;

   always_comb begin
      if (discard_cur) begin
         primary = gen_cancel ? cancel_msg : NULL_MSG;
      end else begin
         primary = cur_evt.is_cancel ? NULL_MSG : new_msg;   // Unmatched cancel ends here
      end
   end

   // Undo the successor first, then replay the rolled-back event
   assign rb_cncl = '{pad: '0, is_cancel: 1'b1, lp: rb_head.target,
                      ts: rb_head.ts + sim_time_t'(rb_head.ofs)};
   assign rb_evt  = '{pad: '0, is_cancel: 1'b0, lp: rb_head.lp, ts: rb_head.ts};

   assign step      = out_valid && ack;
   assign rb_pop    = step && rb_second;
   assign send_done = step && !rb_second && rb_empty;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         out_valid <= 1'b0;
         rb_second <= 1'b0;
      end else if (send_start) begin
         out_valid <= 1'b1;
         rb_second <= 1'b0;
      end else if (step) begin
         if (rb_second) begin
            rb_second <= 1'b0;
         end else if (rb_empty) begin
            out_valid <= 1'b0;     // Last message taken
         end else begin
            rb_second <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (send_start) begin
         out_msg <= primary;
      end else if (step) begin
         out_msg <= rb_second ? rb_evt : rb_cncl;
      end
   end

   // Rolled-back entries in history order
   fwft_fifo #(
      .DEPTH (HIST_DEPTH),
      .WIDTH ($bits(hist_entry_t))
   ) i_rb_buf (
      .clk   (clk),
      .rst_n (rst_n),
      .clear (1'b0),
      .wr_en (rollback),
      .din   (rb_entry),
      .rd_en (rb_pop),
      .dout  (rb_head),
      .empty (rb_empty),
      .full  ()
   );

endmodule

`default_nettype wire

//--- rtl/phold_core.sv
`default_nettype none

module phold_core #(
   parameter int HIST_DEPTH = 16
) (
   input  wire logic                 clk,
   input  wire logic                 rst_n,
   input  wire logic                 event_valid,
   input  wire phold_pkg::evt_msg_t  event_msg,
   input  wire phold_pkg::sim_time_t gvt,
   input  wire phold_pkg::rnd_t      random_in,
   input  wire logic                 ack,
   output logic                      ready,
   output logic                      out_valid,
   output phold_pkg::evt_msg_t       out_msg
);
   import phold_pkg::*;

   localparam int IDX_W = $clog2(HIST_DEPTH);

   evt_msg_t         cur_evt;
   evt_msg_t         new_msg;
   evt_msg_t         cancel_msg;
   sim_time_t        cur_gvt;
   hist_entry_t      new_entry;
   hist_entry_t      rd_entry;
   hist_entry_t      wr_entry;
   hist_cnt_t        hist_cnt;
   hist_cnt_t        new_cnt;
   logic [IDX_W-1:0] rd_idx;
   logic [IDX_W-1:0] wr_idx;
   logic             accept;
   logic             rd_en;
   logic             wr_en;
   logic             set_cnt;
   logic             filt_vld;
   logic             clear;
   logic             keep;
   logic             rollback;
   logic             discard_cur;
   logic             gen_cancel;
   logic             send_start;
   logic             send_done;

   event_decode i_decode (
      .clk       (clk),
      .accept    (accept),
      .event_msg (event_msg),
      .gvt       (gvt),
      .random_in (random_in),
      .cur_evt   (cur_evt),
      .cur_gvt   (cur_gvt),
      .new_msg   (new_msg),
      .new_entry (new_entry)
   );

   event_ctrl #(.HIST_DEPTH(HIST_DEPTH)) i_ctrl (
      .clk         (clk),
      .rst_n       (rst_n),
      .event_valid (event_valid),
      .cur_evt     (cur_evt),
      .new_entry   (new_entry),
      .hist_cnt    (hist_cnt),
      .rd_entry    (rd_entry),
      .keep        (keep),
      .discard_cur (discard_cur),
      .send_done   (send_done),
      .ready       (ready),
      .accept      (accept),
      .rd_en       (rd_en),
      .rd_idx      (rd_idx),
      .filt_vld    (filt_vld),
      .clear       (clear),
      .wr_en       (wr_en),
      .wr_idx      (wr_idx),
      .wr_entry    (wr_entry),
      .set_cnt     (set_cnt),
      .new_cnt     (new_cnt),
      .send_start  (send_start)
   );

   // History of the LP the current event targets
   hist_store #(.HIST_DEPTH(HIST_DEPTH)) i_store (
      .clk      (clk),
      .rst_n    (rst_n),
      .lp       (cur_evt.lp),
      .rd_en    (rd_en),
      .rd_idx   (rd_idx),
      .wr_en    (wr_en),
      .wr_idx   (wr_idx),
      .wr_entry (wr_entry),
      .set_cnt  (set_cnt),
      .new_cnt  (new_cnt),
      .rd_entry (rd_entry),
      .cnt      (hist_cnt)
   );

   hist_filter i_filter (
      .clk         (clk),
      .rst_n       (rst_n),
      .clear       (clear),
      .filt_vld    (filt_vld),
      .entry       (rd_entry),
      .cur_evt     (cur_evt),
      .cur_gvt     (cur_gvt),
      .keep        (keep),
      .rollback    (rollback),
      .discard_cur (discard_cur),
      .gen_cancel  (gen_cancel),
      .cancel_msg  (cancel_msg)
   );

   event_result #(.HIST_DEPTH(HIST_DEPTH)) i_result (
      .clk         (clk),
      .rst_n       (rst_n),
      .rollback    (rollback),
      .rb_entry    (rd_entry),
      .cur_evt     (cur_evt),
      .new_msg     (new_msg),
      .discard_cur (discard_cur),
      .gen_cancel  (gen_cancel),
      .cancel_msg  (cancel_msg),
      .send_start  (send_start),
      .ack         (ack),
      .out_valid   (out_valid),
      .out_msg     (out_msg),
      .send_done   (send_done)
   );

endmodule

`default_nettype wire

//--- tests/tb_clock.sv
`default_nettype none

module tb_clock (
   output logic clk,
   output logic rst_n
);
   timeunit 1ns;
   timeprecision 1ps;

   localparam int RESET_CYCLES = 4;

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;    // 40 ns period
   end

   // Release on a falling edge, like every other testbench input
   initial begin
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
   end

endmodule

`default_nettype wire

//--- tests/tb_phold_core.sv
`default_nettype none

module tb_phold_core;
   timeunit 1ns;
   timeprecision 1ps;

   import phold_pkg::*;

   localparam int DEPTH   = 16;
   localparam int TIMEOUT = 400;    // Cycles allowed for any single wait

   logic        clk;
   logic        rst_n;
   logic        event_valid;
   evt_msg_t    event_msg;
   sim_time_t   gvt;
   rnd_t        random_in;
   logic        ack;
   logic        ready;
   logic        out_valid;
   evt_msg_t    out_msg;

   hist_entry_t hist_mem [NUM_LP][DEPTH];    // Expected history of each LP
   int          hist_len [NUM_LP];
   evt_msg_t    exp_q [$];
   int          errors;
   int          hangs;

   tb_clock i_clock (
      .clk   (clk),
      .rst_n (rst_n)
   );

   phold_core #(.HIST_DEPTH(DEPTH)) i_dut (
      .clk         (clk),
      .rst_n       (rst_n),
      .event_valid (event_valid),
      .event_msg   (event_msg),
      .gvt         (gvt),
      .random_in   (random_in),
      .ack         (ack),
      .ready       (ready),
      .out_valid   (out_valid),
      .out_msg     (out_msg)
   );

   function automatic evt_msg_t make_msg(input logic cncl, input lp_id_t lp, input sim_time_t ts);
      evt_msg_t m;
      m           = '0;
      m.is_cancel = cncl;
      m.lp        = lp;
      m.ts        = ts;
      return m;
   endfunction

   task automatic flag_error(input string msg);
      errors++;
      $display("[ERROR] %0t: %s", $time, msg);
   endtask

   // Filters the LP's history and lists the messages the event must produce
   function automatic void predict(input evt_msg_t ev, input sim_time_t g, input rnd_t r);
      hist_entry_t kept [$];
      hist_entry_t rolled [$];
      hist_entry_t e;
      hist_entry_t ne;
      evt_msg_t    prim;
      sim_time_t   gen_ts;
      logic        matched;
      gen_ts  = ev.ts + MIN_GAP + sim_time_t'(r[4:0]);
      matched = 1'b0;
      prim    = ev.is_cancel ? make_msg(1'b1, '0, '0) : make_msg(1'b0, r[7:5], gen_ts);
      for (int i = 0; i < hist_len[ev.lp]; i++) begin
         e = hist_mem[ev.lp][i];
         if (e.ts < g) begin
            // Expired, simply dropped
         end else if (!matched && e.is_cancel != ev.is_cancel && e.ts == ev.ts) begin
            matched = 1'b1;
            prim    = ev.is_cancel ? make_msg(1'b1, e.target, e.ts + sim_time_t'(e.ofs))
                                   : make_msg(1'b1, '0, '0);
         end else if (!e.is_cancel && !ev.is_cancel && e.ts > ev.ts) begin
            rolled.push_back(e);
         end else begin
            kept.push_back(e);
         end
      end
      if (!matched && kept.size() < DEPTH) begin
         ne           = '0;
         ne.target    = r[7:5];
         ne.ofs       = time_ofs_t'(gen_ts - ev.ts);
         ne.is_cancel = ev.is_cancel;
         ne.lp        = ev.lp;
         ne.ts        = ev.ts;
         kept.push_back(ne);
      end
      hist_len[ev.lp] = kept.size();
      foreach (kept[i]) hist_mem[ev.lp][i] = kept[i];
      exp_q.push_back(prim);
      foreach (rolled[i]) begin
         exp_q.push_back(make_msg(1'b1, rolled[i].target,
                                  rolled[i].ts + sim_time_t'(rolled[i].ofs)));
         exp_q.push_back(make_msg(1'b0, rolled[i].lp, rolled[i].ts));
      end
   endfunction

   task automatic wait_ready();
      int t;
      t = 0;
      while (!ready && t < TIMEOUT) begin
         @(negedge clk);
         t++;
      end
      if (!ready) begin
         hangs++;
         $display("Timeout: the core never raised ready within %0d cycles", TIMEOUT);
      end
   endtask

   task automatic wait_out_valid();
      int t;
      t = 0;
      while (!out_valid && t < TIMEOUT) begin
         @(negedge clk);
         t++;
      end
      if (!out_valid) begin
         hangs++;
         $display("Timeout: no output message appeared within %0d cycles", TIMEOUT);
      end
   endtask

   // Sends one event and acks every message it produces, stalling the first one
   task automatic run_event(input evt_msg_t ev, input sim_time_t g, input int hold);
      rnd_t     r;
      evt_msg_t held;
      int       n;
      if (hangs != 0) return;
      wait_ready();
      if (hangs != 0) return;
      r = rnd_t'($urandom);
      predict(ev, g, r);
      event_valid = 1'b1;
      event_msg   = ev;
      gvt         = g;
      random_in   = r;
      @(negedge clk);
      event_valid = 1'b0;
      assert (!ready) else flag_error("ready still high after the event was taken");
      n = exp_q.size();
      for (int k = 0; k < n; k++) begin
         wait_out_valid();
         if (hangs != 0) return;
         held = out_msg;
         for (int s = 0; s < hold && k == 0; s++) begin
            @(negedge clk);
            assert (out_valid && !ready && out_msg == held)
               else flag_error($sformatf("message %h not held while ack low", held));
         end
         assert (out_msg == exp_q[k])
            else flag_error($sformatf("message %0d is %h, expected %h", k, out_msg, exp_q[k]));
         ack = 1'b1;
         @(negedge clk);
         ack = 1'b0;
      end
      assert (!out_valid && ready)
         else flag_error($sformatf("after %0d messages out_valid=%b ready=%b",
                                   n, out_valid, ready));
      exp_q.delete();
   endtask

   initial begin
      evt_msg_t ev;
      sim_time_t g;
      int        t;
      errors      = 0;
      hangs       = 0;
      event_valid = 1'b0;
      event_msg   = '0;
      gvt         = '0;
      random_in   = '0;
      ack         = 1'b0;
      for (int i = 0; i < NUM_LP; i++) hist_len[i] = 0;
      void'($urandom(72897));
      t = 0;
      while (rst_n !== 1'b1 && t < TIMEOUT) begin
         @(negedge clk);
         t++;
      end
      if (rst_n !== 1'b1) begin
         hangs++;
         $display("Timeout: reset was not released within %0d cycles", TIMEOUT);
      end
      @(negedge clk);
      assert (ready && !out_valid) else flag_error("ready low or out_valid high after reset");

      run_event(make_msg(1'b0, 3'd1, 16'd100), 16'd0, 3);    // Empty history

      // Straggler rolls back four later events, then finds them gone
      for (int i = 0; i < 4; i++) run_event(make_msg(1'b0, 3'd2, 16'(200 + 10 * i)), 16'd0, 0);
      run_event(make_msg(1'b0, 3'd2, 16'd150), 16'd0, 4);
      run_event(make_msg(1'b0, 3'd2, 16'd150), 16'd0, 0);

      // Two equal entries need two cancels
      run_event(make_msg(1'b0, 3'd3, 16'd300), 16'd0, 0);
      run_event(make_msg(1'b0, 3'd3, 16'd300), 16'd0, 0);
      run_event(make_msg(1'b0, 3'd3, 16'd310), 16'd0, 0);
      run_event(make_msg(1'b1, 3'd3, 16'd300), 16'd0, 2);
      run_event(make_msg(1'b1, 3'd3, 16'd300), 16'd0, 0);

      for (int i = 0; i < 3; i++) run_event(make_msg(1'b0, 3'd4, 16'(400 + 10 * i)), 16'd0, 0);
      run_event(make_msg(1'b0, 3'd4, 16'd405), 16'd412, 0);  // 400 and 410 expire
      run_event(make_msg(1'b0, 3'd4, 16'd395), 16'd0, 0);

      run_event(make_msg(1'b1, 3'd5, 16'd500), 16'd0, 0);    // Anti-message arrives first
      run_event(make_msg(1'b0, 3'd5, 16'd500), 16'd0, 0);
      run_event(make_msg(1'b0, 3'd5, 16'd490), 16'd0, 0);

      for (int i = 0; i < 60; i++) begin
         ev = make_msg(($urandom % 4) == 0, lp_id_t'($urandom % 8),
                       sim_time_t'(50 + $urandom % 600));
         g  = sim_time_t'($urandom % 150);
         run_event(ev, g, int'($urandom % 3));
      end

      $display("Summary: %0d wrong values, %0d timeouts", errors, hangs);
      if (errors == 0 && hangs == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- list.f
rtl/phold_pkg.sv
rtl/fwft_fifo.sv
rtl/hist_store.sv
rtl/event_decode.sv
rtl/hist_filter.sv
rtl/event_ctrl.sv
rtl/event_result.sv
rtl/phold_core.sv
tests/tb_clock.sv
tests/tb_phold_core.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f list.f --top-module tb_phold_core -o sim_phold

out=$(./obj_dir/sim_phold)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "NO ERRORS"; then
   exit 0
fi
exit 1
